/* iomem_sysctrl.f */
source/sysctrl_pkg.sv
source/gpio_regs.sv
source/pin_mux.sv
source/sysctrl_bus_slave.sv
source/iomem_sysctrl.sv
dv/tb_clk_gen.sv
dv/iomem_sysctrl_properties.sv
dv/iomem_sysctrl_tb.sv

/* Bender.yml */
package:
  name: iomem_sysctrl

sources:
  - files:
      - source/sysctrl_pkg.sv
      - source/gpio_regs.sv
      - source/pin_mux.sv
      - source/sysctrl_bus_slave.sv
      - source/iomem_sysctrl.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/iomem_sysctrl_properties.sv
      - dv/iomem_sysctrl_tb.sv

/* dv/iomem_sysctrl_tb.sv */
// ------------------------------------------------
// system control slave testbench
// gpio, routing, irq and housekeeping register
// traffic checked against a read-back model
// ------------------------------------------------
`timescale 1ns/100ps

module iomem_sysctrl_tb
  import sysctrl_pkg::*;
();

  localparam int CLK_PERIOD_NS = 8;
  localparam int GPIO_ITERS    = 24;
  localparam int HK_ROUNDS     = 2;
  localparam int READY_LIMIT   = 8;
  // gpio, routing, irq, housekeeping and unmapped phases
  localparam int N_XFERS     = 2 * GPIO_ITERS + 21 + 16 + HK_ROUNDS * 7 + 6;
  localparam int WATCHDOG_NS = N_XFERS * 4 * CLK_PERIOD_NS + 1000;

  logic        clk, rst_n;
  logic        iomem_valid, iomem_ready;
  reg_offset_t iomem_addr;
  byte_en_t    iomem_wstrb;
  bus_data_t   iomem_wdata, iomem_rdata;
  logic        xtal_in, clk_pll, trap;
  logic [7:0]  hk_config, hk_prod_id;
  logic        hk_xtal_ena, hk_reg_ena, clk_ext_sel;
  logic        hk_pll_cp_ena, hk_pll_vco_ena, hk_pll_bias_ena;
  logic [3:0]  hk_pll_trim, hk_mask_rev;
  logic [11:0] hk_mfgr_id;
  gpio_t       gpio_in, gpio_out, gpio_outenb, gpio_pullupb, gpio_pulldownb;
  logic        irq_7, irq_8;

  int          errors = 0;
  integer      seed = 32'he909;
  gpio_t       regs_m [4];
  reg_offset_t gpio_offs [4] = '{OFF_GPIO_DATA, OFF_GPIO_OEB, OFF_GPIO_PU, OFF_GPIO_PD};
  string       gpio_names [4] = '{"gpio_data", "gpio_oeb", "gpio_pu", "gpio_pd"};
  reg_offset_t route_offs [3] = '{OFF_XTAL_DEST, OFF_PLL_DEST, OFF_TRAP_DEST};
  string       route_names [3] = '{"xtal_dest", "pll_dest", "trap_dest"};

  tb_clk_gen tb_clk_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  iomem_sysctrl iomem_sysctrl_inst (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .iomem_valid_i     (iomem_valid),
    .iomem_addr_i      (iomem_addr),
    .iomem_wstrb_i     (iomem_wstrb),
    .iomem_wdata_i     (iomem_wdata),
    .iomem_ready_o     (iomem_ready),
    .iomem_rdata_o     (iomem_rdata),
    .xtal_in_i         (xtal_in),
    .clk_pll_i         (clk_pll),
    .trap_i            (trap),
    .hk_config_i       (hk_config),
    .hk_xtal_ena_i     (hk_xtal_ena),
    .hk_reg_ena_i      (hk_reg_ena),
    .hk_pll_cp_ena_i   (hk_pll_cp_ena),
    .hk_pll_vco_ena_i  (hk_pll_vco_ena),
    .hk_pll_bias_ena_i (hk_pll_bias_ena),
    .hk_pll_trim_i     (hk_pll_trim),
    .hk_mfgr_id_i      (hk_mfgr_id),
    .hk_prod_id_i      (hk_prod_id),
    .hk_mask_rev_i     (hk_mask_rev),
    .clk_ext_sel_i     (clk_ext_sel),
    .gpio_in_i         (gpio_in),
    .gpio_out_o        (gpio_out),
    .gpio_outenb_o     (gpio_outenb),
    .gpio_pullupb_o    (gpio_pullupb),
    .gpio_pulldownb_o  (gpio_pulldownb),
    .irq_7_o           (irq_7),
    .irq_8_o           (irq_8)
  );

  bind iomem_sysctrl iomem_sysctrl_properties iomem_sysctrl_properties_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (iomem_valid_i),
    .ready_i     (iomem_ready_o),
    .xtal_in_i   (xtal_in_i),
    .clk_pll_i   (clk_pll_i),
    .trap_i      (trap_i),
    .xtal_dest_i (xtal_dest),
    .pll_dest_i  (pll_dest),
    .trap_dest_i (trap_dest),
    .gpio_reg_i  (gpio_q),
    .oeb_reg_i   (gpio_oeb),
    .pu_reg_i    (gpio_pu),
    .pd_reg_i    (gpio_pd),
    .gpio_out_i  (gpio_out_o),
    .outenb_i    (gpio_outenb_o),
    .pullupb_i   (gpio_pullupb_o),
    .pulldownb_i (gpio_pulldownb_o)
  );

  // one request, held until ready, response sampled mid-cycle
  task automatic bus_xfer(input reg_offset_t addr, input byte_en_t strb,
                          input bus_data_t wdata, output bus_data_t rdata);
    int waited;
    @(posedge clk);
    #1;
    iomem_valid = 1'b1;
    iomem_addr  = addr;
    iomem_wstrb = strb;
    iomem_wdata = wdata;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!iomem_ready && waited < READY_LIMIT);
    if (!iomem_ready) begin
      errors++;
      $display("ERROR: no ready within %0d cycles at offset 0x%02h", READY_LIMIT, addr);
    end
    rdata = iomem_rdata;
    @(posedge clk);
    #1;
    iomem_valid = 1'b0;
    iomem_wstrb = '0;
  endtask

  task automatic check_value(input string name, input bus_data_t exp, input bus_data_t act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected 0x%08h actual 0x%08h", name, exp, act);
    end
  endtask

  task automatic read_check(input string name, input reg_offset_t addr, input bus_data_t exp);
    bus_data_t rd;
    bus_xfer(addr, 4'b0000, '0, rd);
    check_value(name, exp, rd);
  endtask

  // byte lanes 0 and 1 follow strobe bits 0 and 1
  function automatic gpio_t lanes_written(gpio_t old, bus_data_t wdata, byte_en_t strb);
    gpio_t res;
    res = old;
    for (int b = 0; b < 2; b++) begin
      if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic selected_irq(int code, int first_pin, gpio_t pins);
    if (code == 0) return 1'b0;
    else return pins[first_pin + code - 1];
  endfunction

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    bus_data_t   rd, wdata, exp;
    logic [31:0] rnd;
    int          idx, asrt_fails;
    byte_en_t    strb;
    iomem_valid = 1'b0;
    iomem_addr  = '0;
    iomem_wstrb = '0;
    iomem_wdata = '0;
    {xtal_in, clk_pll, trap} = 3'b000;
    {hk_config, hk_prod_id, hk_mfgr_id, hk_pll_trim, hk_mask_rev} = '0;
    {hk_xtal_ena, hk_reg_ena, clk_ext_sel} = 3'b000;
    {hk_pll_cp_ena, hk_pll_vco_ena, hk_pll_bias_ena} = 3'b000;
    gpio_in = '0;
    regs_m  = '{GPIO_RESET, GPIO_OEB_RESET, GPIO_RESET, GPIO_RESET};
    @(posedge rst_n);

    // gpio registers in rotation, random lanes, routing still off
    for (int i = 0; i < GPIO_ITERS; i++) begin
      rnd     = $random(seed);
      idx     = i % 4;
      strb    = rnd[7:4];
      gpio_in = rnd[31:16];
      wdata   = $random(seed);
      bus_xfer(gpio_offs[idx], strb, wdata, rd);
      if (strb != '0) regs_m[idx] = lanes_written(regs_m[idx], wdata, strb);
      exp = (idx == 0) ? {regs_m[0], gpio_in} : bus_data_t'(regs_m[idx]);
      read_check(gpio_names[idx], gpio_offs[idx], exp);
    end

    // each routing code in turn, sources toggling
    for (int g = 0; g < 3; g++) begin
      for (int code = 1; code < 4; code++) begin
        wdata = $random(seed);
        bus_xfer(route_offs[g], 4'b0001, {wdata[31:2], 2'(code)}, rd);
        read_check(route_names[g], route_offs[g], bus_data_t'(code));
        repeat (4) begin
          @(posedge clk);
          #1;
          rnd = $random(seed);
          {xtal_in, clk_pll, trap} = rnd[2:0];
        end
      end
      bus_xfer(route_offs[g], 4'b0001, '0, rd);
    end

    // irq source select against random inputs
    for (int code = 0; code < 4; code++) begin
      bus_xfer(OFF_IRQ7_SRC, 4'b0001, bus_data_t'(code), rd);
      bus_xfer(OFF_IRQ8_SRC, 4'b0001, bus_data_t'(3 - code), rd);
      read_check("irq7_src", OFF_IRQ7_SRC, bus_data_t'(code));
      read_check("irq8_src", OFF_IRQ8_SRC, bus_data_t'(3 - code));
      repeat (4) begin
        @(posedge clk);
        #1;
        rnd     = $random(seed);
        gpio_in = rnd[15:0];
        @(negedge clk);
        check_value("irq_7", bus_data_t'(selected_irq(code, 0, gpio_in)), bus_data_t'(irq_7));
        check_value("irq_8", bus_data_t'(selected_irq(3 - code, 3, gpio_in)),
                    bus_data_t'(irq_8));
      end
    end

    // housekeeping read-back
    for (int r = 0; r < HK_ROUNDS; r++) begin
      rnd = $random(seed);
      hk_config   = rnd[7:0];
      {hk_xtal_ena, hk_reg_ena} = rnd[9:8];
      {hk_pll_cp_ena, hk_pll_vco_ena, hk_pll_bias_ena} = rnd[12:10];
      hk_pll_trim = rnd[16:13];
      hk_mask_rev = rnd[20:17];
      clk_ext_sel = rnd[21];
      hk_prod_id  = rnd[29:22];
      rnd = $random(seed);
      hk_mfgr_id  = rnd[11:0];
      read_check("hk_config", OFF_HK_CONFIG, bus_data_t'(hk_config));
      exp = (bus_data_t'(hk_xtal_ena) << 1) | bus_data_t'(hk_reg_ena);
      read_check("hk_ena", OFF_HK_ENA, exp);
      exp = (bus_data_t'(hk_pll_trim) << 3) | (bus_data_t'(hk_pll_cp_ena) << 2)
          | (bus_data_t'(hk_pll_vco_ena) << 1) | bus_data_t'(hk_pll_bias_ena);
      read_check("hk_pll", OFF_HK_PLL, exp);
      read_check("hk_mfgr", OFF_HK_MFGR, bus_data_t'(hk_mfgr_id));
      read_check("hk_prod", OFF_HK_PROD, bus_data_t'(hk_prod_id));
      read_check("hk_mask", OFF_HK_MASK, bus_data_t'(hk_mask_rev));
      read_check("clk_ext_sel", OFF_CLK_EXT_SEL, bus_data_t'(clk_ext_sel));
    end

    // holes in the map read zero and drop writes
    bus_xfer(8'h10, 4'b1111, '1, rd);
    read_check("unmapped_10", 8'h10, '0);
    read_check("unmapped_14", 8'h14, '0);
    read_check("unmapped_48", 8'h48, '0);
    read_check("unmapped_fc", 8'hFC, '0);
    read_check("gpio_oeb_kept", OFF_GPIO_OEB, bus_data_t'(regs_m[1]));

    repeat (2) @(posedge clk);
    asrt_fails = iomem_sysctrl_inst.iomem_sysctrl_properties_inst.fail_cnt;
    $display("errors: %0d check, %0d assertion", errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* dv/iomem_sysctrl_properties.sv */
// ------------------------------------------------
// system control checkers
// handshake, reset state and pad override rules
// ------------------------------------------------
`timescale 1ns/100ps

module iomem_sysctrl_properties
  import sysctrl_pkg::*;
(
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       valid_i,
  input logic       ready_i,
  input logic       xtal_in_i,
  input logic       clk_pll_i,
  input logic       trap_i,
  input route_sel_t xtal_dest_i,
  input route_sel_t pll_dest_i,
  input route_sel_t trap_dest_i,
  input gpio_t      gpio_reg_i,
  input gpio_t      oeb_reg_i,
  input gpio_t      pu_reg_i,
  input gpio_t      pd_reg_i,
  input gpio_t      gpio_out_i,
  input gpio_t      outenb_i,
  input gpio_t      pullupb_i,
  input gpio_t      pulldownb_i
);

  int    fail_cnt = 0;
  gpio_t ovr;
  gpio_t exp_out;

  // expected pads: xtal on 5..7, pll on 8..10, trap on 11..13
  always_comb begin
    ovr     = '0;
    exp_out = gpio_reg_i;
    if (xtal_dest_i != 2'd0) begin
      ovr[7:5] = 3'b111;
      exp_out[4 + int'(xtal_dest_i)] = xtal_in_i;
    end
    if (pll_dest_i != 2'd0) begin
      ovr[10:8] = 3'b111;
      if (pll_dest_i == 2'd1) exp_out[8] = clk_pll_i;
      if (pll_dest_i == 2'd2) exp_out[9] = clk_i;
    end
    if (trap_dest_i != 2'd0) begin
      ovr[13:11] = 3'b111;
      exp_out[10 + int'(trap_dest_i)] = trap_i;
    end
  end

  a_reset_state: assert property (@(posedge clk_i)
    (!rst_n_i || $rose(rst_n_i)) |-> (outenb_i == '1 && gpio_out_i == '0 && !ready_i))
    else begin
      fail_cnt++;
      $error("pads or ready left their reset state");
    end

  a_ready_after_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_i && !ready_i) |=> ready_i)
    else begin
      fail_cnt++;
      $error("ready missing one cycle after a new request");
    end

  a_ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ready_i |=> !ready_i)
    else begin
      fail_cnt++;
      $error("ready held high for more than one cycle");
    end

  a_ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ready_i) |-> $past(valid_i))
    else begin
      fail_cnt++;
      $error("ready rose without a request");
    end

  a_pad_out: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gpio_out_i == exp_out)
    else begin
      fail_cnt++;
      $error("pad output does not follow routing");
    end

  // pll code 2 forwards clk_i, so the high clock phase needs its own look
  a_pad_out_high: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    gpio_out_i == exp_out)
    else begin
      fail_cnt++;
      $error("pad output does not follow routing in the high clock phase");
    end

  a_pad_enable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    outenb_i == (oeb_reg_i & ~ovr))
    else begin
      fail_cnt++;
      $error("pad output enable wrong");
    end

  a_pad_pulls: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pullupb_i == (pu_reg_i | ovr) && pulldownb_i == (pd_reg_i | ovr))
    else begin
      fail_cnt++;
      $error("pad pull controls wrong");
    end

endmodule

/* dv/tb_clk_gen.sv */
// ------------------------------------------------
// testbench clock and reset
// 8 ns clock, reset held low for 3 cycles
// ------------------------------------------------
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    // release just after the edge, like the bus stimulus
    #1 rst_n_o = 1'b1;
  end

  always #4 clk_o = ~clk_o;

endmodule

/* source/iomem_sysctrl.sv */
// ------------------------------------------------
// system control slave, top level
// bus slave, gpio registers and pad mux for the
// 0x0300_00xx register window
// ------------------------------------------------
`timescale 1ns/100ps

module iomem_sysctrl
  import sysctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        iomem_valid_i,
  input  reg_offset_t iomem_addr_i,
  input  byte_en_t    iomem_wstrb_i,
  input  bus_data_t   iomem_wdata_i,
  output logic        iomem_ready_o,
  output bus_data_t   iomem_rdata_o,
  input  logic        xtal_in_i,
  input  logic        clk_pll_i,
  input  logic        trap_i,
  input  logic [7:0]  hk_config_i,
  input  logic        hk_xtal_ena_i,
  input  logic        hk_reg_ena_i,
  input  logic        hk_pll_cp_ena_i,
  input  logic        hk_pll_vco_ena_i,
  input  logic        hk_pll_bias_ena_i,
  input  logic [3:0]  hk_pll_trim_i,
  input  logic [11:0] hk_mfgr_id_i,
  input  logic [7:0]  hk_prod_id_i,
  input  logic [3:0]  hk_mask_rev_i,
  input  logic        clk_ext_sel_i,
  input  gpio_t       gpio_in_i,
  output gpio_t       gpio_out_o,
  output gpio_t       gpio_outenb_o,
  output gpio_t       gpio_pullupb_o,
  output gpio_t       gpio_pulldownb_o,
  output logic        irq_7_o,
  output logic        irq_8_o
);

  logic        wr_en;
  reg_offset_t wr_offset;
  byte_en_t    wr_strb;
  bus_data_t   wr_data;
  gpio_t       gpio_q;
  gpio_t       gpio_oeb;
  gpio_t       gpio_pu;
  gpio_t       gpio_pd;
  route_sel_t  xtal_dest, pll_dest, trap_dest, irq7_src, irq8_src;

  sysctrl_bus_slave sysctrl_bus_slave_inst (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .iomem_valid_i     (iomem_valid_i),
    .iomem_addr_i      (iomem_addr_i),
    .iomem_wstrb_i     (iomem_wstrb_i),
    .iomem_wdata_i     (iomem_wdata_i),
    .iomem_ready_o     (iomem_ready_o),
    .iomem_rdata_o     (iomem_rdata_o),
    .wr_en_o           (wr_en),
    .wr_offset_o       (wr_offset),
    .wr_strb_o         (wr_strb),
    .wr_data_o         (wr_data),
    // data reads back the final pad value, not the raw register
    .gpio_out_i        (gpio_out_o),
    .gpio_in_i         (gpio_in_i),
    .gpio_oeb_i        (gpio_oeb),
    .gpio_pu_i         (gpio_pu),
    .gpio_pd_i         (gpio_pd),
    .xtal_dest_i       (xtal_dest),
    .pll_dest_i        (pll_dest),
    .trap_dest_i       (trap_dest),
    .irq7_src_i        (irq7_src),
    .irq8_src_i        (irq8_src),
    .hk_config_i       (hk_config_i),
    .hk_xtal_ena_i     (hk_xtal_ena_i),
    .hk_reg_ena_i      (hk_reg_ena_i),
    .hk_pll_cp_ena_i   (hk_pll_cp_ena_i),
    .hk_pll_vco_ena_i  (hk_pll_vco_ena_i),
    .hk_pll_bias_ena_i (hk_pll_bias_ena_i),
    .hk_pll_trim_i     (hk_pll_trim_i),
    .hk_mfgr_id_i      (hk_mfgr_id_i),
    .hk_prod_id_i      (hk_prod_id_i),
    .hk_mask_rev_i     (hk_mask_rev_i),
    .clk_ext_sel_i     (clk_ext_sel_i)
  );

  gpio_regs gpio_regs_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wr_en_i     (wr_en),
    .wr_offset_i (wr_offset),
    .wr_strb_i   (wr_strb),
    .wr_data_i   (wr_data),
    .gpio_o      (gpio_q),
    .gpio_oeb_o  (gpio_oeb),
    .gpio_pu_o   (gpio_pu),
    .gpio_pd_o   (gpio_pd)
  );

  pin_mux pin_mux_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .wr_en_i          (wr_en),
    .wr_offset_i      (wr_offset),
    .wr_strb_i        (wr_strb),
    .wr_data_i        (wr_data),
    .gpio_i           (gpio_q),
    .gpio_oeb_i       (gpio_oeb),
    .gpio_pu_i        (gpio_pu),
    .gpio_pd_i        (gpio_pd),
    .xtal_in_i        (xtal_in_i),
    .clk_pll_i        (clk_pll_i),
    .trap_i           (trap_i),
    .gpio_in_i        (gpio_in_i),
    .xtal_dest_o      (xtal_dest),
    .pll_dest_o       (pll_dest),
    .trap_dest_o      (trap_dest),
    .irq7_src_o       (irq7_src),
    .irq8_src_o       (irq8_src),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o),
    .irq_7_o          (irq_7_o),
    .irq_8_o          (irq_8_o)
  );

endmodule

/* source/sysctrl_bus_slave.sv */
// ------------------------------------------------
// native valid/ready bus slave
// one-cycle ready, write commit pulse and the
// registered read-back multiplexer
// ------------------------------------------------
`timescale 1ns/100ps

module sysctrl_bus_slave
  import sysctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        iomem_valid_i,
  input  reg_offset_t iomem_addr_i,
  input  byte_en_t    iomem_wstrb_i,
  input  bus_data_t   iomem_wdata_i,
  output logic        iomem_ready_o,
  output bus_data_t   iomem_rdata_o,
  output logic        wr_en_o,
  output reg_offset_t wr_offset_o,
  output byte_en_t    wr_strb_o,
  output bus_data_t   wr_data_o,
  input  gpio_t       gpio_out_i,
  input  gpio_t       gpio_in_i,
  input  gpio_t       gpio_oeb_i,
  input  gpio_t       gpio_pu_i,
  input  gpio_t       gpio_pd_i,
  input  route_sel_t  xtal_dest_i,
  input  route_sel_t  pll_dest_i,
  input  route_sel_t  trap_dest_i,
  input  route_sel_t  irq7_src_i,
  input  route_sel_t  irq8_src_i,
  input  logic [7:0]  hk_config_i,
  input  logic        hk_xtal_ena_i,
  input  logic        hk_reg_ena_i,
  input  logic        hk_pll_cp_ena_i,
  input  logic        hk_pll_vco_ena_i,
  input  logic        hk_pll_bias_ena_i,
  input  logic [3:0]  hk_pll_trim_i,
  input  logic [11:0] hk_mfgr_id_i,
  input  logic [7:0]  hk_prod_id_i,
  input  logic [3:0]  hk_mask_rev_i,
  input  logic        clk_ext_sel_i
);

  logic      ready_q;
  logic      accept;
  bus_data_t rdata_d;
  bus_data_t rdata_q;

  // first cycle of a request that has not been answered yet
  assign accept = iomem_valid_i && !ready_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  // registers commit on the same edge that raises ready
  assign wr_en_o     = accept && (iomem_wstrb_i != '0);
  assign wr_offset_o = iomem_addr_i;
  assign wr_strb_o   = iomem_wstrb_i;
  assign wr_data_o   = iomem_wdata_i;

  always_comb begin
    case (iomem_addr_i)
      OFF_GPIO_DATA:   rdata_d = {gpio_out_i, gpio_in_i};
      OFF_GPIO_OEB:    rdata_d = bus_data_t'(gpio_oeb_i);
      OFF_GPIO_PU:     rdata_d = bus_data_t'(gpio_pu_i);
      OFF_GPIO_PD:     rdata_d = bus_data_t'(gpio_pd_i);
      OFF_HK_CONFIG:   rdata_d = bus_data_t'(hk_config_i);
      OFF_HK_ENA:      rdata_d = bus_data_t'({hk_xtal_ena_i, hk_reg_ena_i});
      OFF_HK_PLL: begin
        rdata_d = bus_data_t'({hk_pll_trim_i, hk_pll_cp_ena_i,
                               hk_pll_vco_ena_i, hk_pll_bias_ena_i});
      end
      OFF_HK_MFGR:     rdata_d = bus_data_t'(hk_mfgr_id_i);
      OFF_HK_PROD:     rdata_d = bus_data_t'(hk_prod_id_i);
      OFF_HK_MASK:     rdata_d = bus_data_t'(hk_mask_rev_i);
      OFF_CLK_EXT_SEL: rdata_d = bus_data_t'(clk_ext_sel_i);
      OFF_XTAL_DEST:   rdata_d = bus_data_t'(xtal_dest_i);
      OFF_PLL_DEST:    rdata_d = bus_data_t'(pll_dest_i);
      OFF_TRAP_DEST:   rdata_d = bus_data_t'(trap_dest_i);
      OFF_IRQ7_SRC:    rdata_d = bus_data_t'(irq7_src_i);
      OFF_IRQ8_SRC:    rdata_d = bus_data_t'(irq8_src_i);
      default:         rdata_d = '0;
    endcase
  end

  // sampled before the write lands, so reads show the old value
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= rdata_d;
    end
  end

  assign iomem_ready_o = ready_q;
  assign iomem_rdata_o = rdata_q;

endmodule

/* source/pin_mux.sv */
// ------------------------------------------------
// pad routing and irq source select
// puts crystal, pll, core clock or trap onto fixed
// gpio pads and picks gpio inputs for irq 7 and 8
// ------------------------------------------------
`timescale 1ns/100ps

module pin_mux
  import sysctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        wr_en_i,
  input  reg_offset_t wr_offset_i,
  input  byte_en_t    wr_strb_i,
  input  bus_data_t   wr_data_i,
  input  gpio_t       gpio_i,
  input  gpio_t       gpio_oeb_i,
  input  gpio_t       gpio_pu_i,
  input  gpio_t       gpio_pd_i,
  input  logic        xtal_in_i,
  input  logic        clk_pll_i,
  input  logic        trap_i,
  input  gpio_t       gpio_in_i,
  output route_sel_t  xtal_dest_o,
  output route_sel_t  pll_dest_o,
  output route_sel_t  trap_dest_o,
  output route_sel_t  irq7_src_o,
  output route_sel_t  irq8_src_o,
  output gpio_t       gpio_out_o,
  output gpio_t       gpio_outenb_o,
  output gpio_t       gpio_pullupb_o,
  output gpio_t       gpio_pulldownb_o,
  output logic        irq_7_o,
  output logic        irq_8_o
);

  route_sel_t xtal_q, pll_q, trap_q, irq7_q, irq8_q;
  gpio_t      ovr_mask;
  gpio_t      drv_mask;
  gpio_t      drv_val;

  // routing codes live in data bits 1:0, byte lane 0 only
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      xtal_q <= '0;
      pll_q  <= '0;
      trap_q <= '0;
      irq7_q <= '0;
      irq8_q <= '0;
    end else if (wr_en_i && wr_strb_i[0]) begin
      case (wr_offset_i)
        OFF_XTAL_DEST: xtal_q <= wr_data_i[ROUTE_W-1:0];
        OFF_PLL_DEST:  pll_q  <= wr_data_i[ROUTE_W-1:0];
        OFF_TRAP_DEST: trap_q <= wr_data_i[ROUTE_W-1:0];
        OFF_IRQ7_SRC:  irq7_q <= wr_data_i[ROUTE_W-1:0];
        OFF_IRQ8_SRC:  irq8_q <= wr_data_i[ROUTE_W-1:0];
        default: ;
      endcase
    end
  end

  // any non-zero code takes over the whole three-pad group
  always_comb begin
    ovr_mask = '0;
    drv_mask = '0;
    drv_val  = '0;
    drv_val[PAD_XTAL_BASE +: 3] = {3{xtal_in_i}};
    drv_val[PAD_PLL_BASE]       = clk_pll_i;
    drv_val[PAD_PLL_BASE + 1]   = clk_i;
    drv_val[PAD_TRAP_BASE +: 3] = {3{trap_i}};
    if (xtal_q != '0) begin
      ovr_mask[PAD_XTAL_BASE +: 3]               = 3'b111;
      drv_mask[PAD_XTAL_BASE + int'(xtal_q) - 1] = 1'b1;
    end
    if (pll_q != '0) begin
      ovr_mask[PAD_PLL_BASE +: 3] = 3'b111;
      // code 3 claims the group but drives nothing
      if (pll_q != 2'd3) drv_mask[PAD_PLL_BASE + int'(pll_q) - 1] = 1'b1;
    end
    if (trap_q != '0) begin
      ovr_mask[PAD_TRAP_BASE +: 3]               = 3'b111;
      drv_mask[PAD_TRAP_BASE + int'(trap_q) - 1] = 1'b1;
    end
  end

  assign gpio_out_o       = (gpio_i & ~drv_mask) | (drv_val & drv_mask);
  // pads stay inputs while reset is held
  assign gpio_outenb_o    = {GPIO_W{~rst_n_i}} | (gpio_oeb_i & ~ovr_mask);
  assign gpio_pullupb_o   = gpio_pu_i | ovr_mask;
  assign gpio_pulldownb_o = gpio_pd_i | ovr_mask;

  assign irq_7_o = (irq7_q == '0) ? 1'b0 : gpio_in_i[IRQ7_GPIO_BASE + int'(irq7_q) - 1];
  assign irq_8_o = (irq8_q == '0) ? 1'b0 : gpio_in_i[IRQ8_GPIO_BASE + int'(irq8_q) - 1];

  assign xtal_dest_o = xtal_q;
  assign pll_dest_o  = pll_q;
  assign trap_dest_o = trap_q;
  assign irq7_src_o  = irq7_q;
  assign irq8_src_o  = irq8_q;

endmodule

/* source/gpio_regs.sv */
// ------------------------------------------------
// gpio pad registers
// data, output enable, pull-up and pull-down with
// independent byte-lane writes
// ------------------------------------------------
`timescale 1ns/100ps

module gpio_regs
  import sysctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        wr_en_i,
  input  reg_offset_t wr_offset_i,
  input  byte_en_t    wr_strb_i,
  input  bus_data_t   wr_data_i,
  output gpio_t       gpio_o,
  output gpio_t       gpio_oeb_o,
  output gpio_t       gpio_pu_o,
  output gpio_t       gpio_pd_o
);

  gpio_t gpio_q, oeb_q, pu_q, pd_q;

  // update the low and high byte lane on their own strobes
  function automatic gpio_t lane_merge(gpio_t cur, bus_data_t d, byte_en_t s);
    gpio_t res;
    res = cur;
    if (s[0]) res[7:0] = d[7:0];
    if (s[1]) res[15:8] = d[15:8];
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_q <= GPIO_RESET;
      oeb_q  <= GPIO_OEB_RESET;
      pu_q   <= GPIO_RESET;
      pd_q   <= GPIO_RESET;
    end else if (wr_en_i) begin
      case (wr_offset_i)
        OFF_GPIO_DATA: gpio_q <= lane_merge(gpio_q, wr_data_i, wr_strb_i);
        OFF_GPIO_OEB:  oeb_q  <= lane_merge(oeb_q, wr_data_i, wr_strb_i);
        OFF_GPIO_PU:   pu_q   <= lane_merge(pu_q, wr_data_i, wr_strb_i);
        OFF_GPIO_PD:   pd_q   <= lane_merge(pd_q, wr_data_i, wr_strb_i);
        default: ;
      endcase
    end
  end

  assign gpio_o     = gpio_q;
  assign gpio_oeb_o = oeb_q;
  assign gpio_pu_o  = pu_q;
  assign gpio_pd_o  = pd_q;

endmodule

/* source/sysctrl_pkg.sv */
// ------------------------------------------------
// system control package
// register map, field widths and reset values for
// the memory-mapped system control slave
// ------------------------------------------------
package sysctrl_pkg;

  localparam int BUS_DW  = 32;
  localparam int OFF_W   = 8;
  localparam int STRB_W  = BUS_DW / 8;
  localparam int GPIO_W  = 16;
  localparam int ROUTE_W = 2;

  typedef logic [BUS_DW-1:0]  bus_data_t;
  typedef logic [OFF_W-1:0]   reg_offset_t;
  typedef logic [STRB_W-1:0]  byte_en_t;
  typedef logic [GPIO_W-1:0]  gpio_t;
  // zero means the route or source is off
  typedef logic [ROUTE_W-1:0] route_sel_t;

  // gpio pad registers
  localparam reg_offset_t OFF_GPIO_DATA   = 8'h00;
  localparam reg_offset_t OFF_GPIO_OEB    = 8'h04;
  localparam reg_offset_t OFF_GPIO_PU     = 8'h08;
  localparam reg_offset_t OFF_GPIO_PD     = 8'h0C;
  // read-only housekeeping info
  localparam reg_offset_t OFF_HK_CONFIG   = 8'h18;
  localparam reg_offset_t OFF_HK_ENA      = 8'h1C;
  localparam reg_offset_t OFF_HK_PLL      = 8'h20;
  localparam reg_offset_t OFF_HK_MFGR     = 8'h24;
  localparam reg_offset_t OFF_HK_PROD     = 8'h28;
  localparam reg_offset_t OFF_HK_MASK     = 8'h2C;
  localparam reg_offset_t OFF_CLK_EXT_SEL = 8'h30;
  // pad routing and irq source select
  localparam reg_offset_t OFF_XTAL_DEST   = 8'h34;
  localparam reg_offset_t OFF_PLL_DEST    = 8'h38;
  localparam reg_offset_t OFF_TRAP_DEST   = 8'h3C;
  localparam reg_offset_t OFF_IRQ7_SRC    = 8'h40;
  localparam reg_offset_t OFF_IRQ8_SRC    = 8'h44;

  // all pads come up as inputs
  localparam gpio_t GPIO_OEB_RESET = '1;
  localparam gpio_t GPIO_RESET     = '0;

  // first pad of each routing group, first gpio input per irq
  localparam int PAD_XTAL_BASE  = 5;
  localparam int PAD_PLL_BASE   = 8;
  localparam int PAD_TRAP_BASE  = 11;
  localparam int IRQ7_GPIO_BASE = 0;
  localparam int IRQ8_GPIO_BASE = 3;

endpackage
